// File: build.f
common/core_cfg_pkg.sv
common/uop_pkg.sv
dispatch/dispatch_router.sv
dispatch/dispatch_perf.sv
rs/rs_queue.sv
design/dispatch_top.sv
dv/dispatch_tb.sv

// File: dv/dispatch_tb.sv
`timescale 1ns/1ns

module dispatch_tb;

    localparam int ID_WIDTH   = 2;
    localparam int DEPTHS [4] = '{8, 4, 4, 8};   // INT, INTM, BR, MEM
    localparam int N_GROUPS   = 400;
    localparam int SLOTS      = 64;              // Model ring larger than any station
    localparam int CLK_PERIOD = 100;

    logic                    clk;
    logic                    rst;
    logic                    in_valid;
    logic                    in_ready;
    logic                    lane_valid [ID_WIDTH];
    uop_pkg::rs_class_t      lane_class [ID_WIDTH];
    core_cfg_pkg::op_t       lane_op    [ID_WIDTH];
    core_cfg_pkg::phys_reg_t lane_rd    [ID_WIDTH];

    // Issue ports and counters indexed by station class
    logic                    iss_valid [4];
    logic                    iss_ready [4];
    core_cfg_pkg::op_t       iss_op    [4];
    core_cfg_pkg::phys_reg_t iss_rd    [4];
    core_cfg_pkg::perf_cnt_t perf_cnt  [4];

    // Reference model state
    core_cfg_pkg::op_t       exp_op    [4][SLOTS];
    core_cfg_pkg::phys_reg_t exp_rd    [4][SLOTS];
    core_cfg_pkg::perf_cnt_t exp_stall [4];
    int exp_head [4];
    int exp_tail [4];
    int issued   [4];

    int          err_value;
    int          err_other;
    string       test_name;
    int unsigned seed;

    dispatch_top i_dispatch_top (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_ready(in_ready),
        .lane_valid(lane_valid), .lane_class(lane_class), .lane_op(lane_op), .lane_rd(lane_rd),
        .int_issue_valid(iss_valid[0]), .int_issue_ready(iss_ready[0]),
        .int_issue_op(iss_op[0]), .int_issue_rd(iss_rd[0]),
        .intm_issue_valid(iss_valid[1]), .intm_issue_ready(iss_ready[1]),
        .intm_issue_op(iss_op[1]), .intm_issue_rd(iss_rd[1]),
        .br_issue_valid(iss_valid[2]), .br_issue_ready(iss_ready[2]),
        .br_issue_op(iss_op[2]), .br_issue_rd(iss_rd[2]),
        .mem_issue_valid(iss_valid[3]), .mem_issue_ready(iss_ready[3]),
        .mem_issue_op(iss_op[3]), .mem_issue_rd(iss_rd[3]),
        .perf_int_stall(perf_cnt[0]), .perf_intm_stall(perf_cnt[1]),
        .perf_br_stall(perf_cnt[2]), .perf_mem_stall(perf_cnt[3])
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Watchdog sized from the group count
    initial begin
        #(CLK_PERIOD * (N_GROUPS * 4 + 200));
        $display("Timeout: run did not finish within %0d clock periods", N_GROUPS * 4 + 200);
        $display("ERRORS FOUND");
        $finish;
    end

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            err_value++;
            $display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic check_op(input string what, input core_cfg_pkg::op_t exp,
                            input core_cfg_pkg::op_t act);
        if (act !== exp) begin
            err_value++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reg(input string what, input core_cfg_pkg::phys_reg_t exp,
                             input core_cfg_pkg::phys_reg_t act);
        if (act !== exp) begin
            err_value++;
            $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_cnt(input string what, input core_cfg_pkg::perf_cnt_t exp,
                             input core_cfg_pkg::perf_cnt_t act);
        if (act !== exp) begin
            err_value++;
            $display("** Error [%s] %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic string class_name(input int c);
        case (c)
            0:       return "int";
            1:       return "intm";
            2:       return "br";
            default: return "mem";
        endcase
    endfunction

    // Free entries must cover the full write width without credit for pops
    function automatic logic class_room(input int c);
        int width;
        width = (c <= 1) ? ID_WIDTH : 1;
        return (DEPTHS[c] - (exp_tail[c] - exp_head[c])) >= width;
    endfunction

    function automatic logic predict_ready();
        logic rdy;
        rdy = 1'b1;
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (lane_valid[i] && !class_room(int'(lane_class[i]))) rdy = 1'b0;
        end
        return rdy;
    endfunction

    task automatic check_issue(input int c);
        logic exp_valid;
        exp_valid = (exp_tail[c] != exp_head[c]);
        check_bit({class_name(c), " issue_valid"}, exp_valid, iss_valid[c]);
        if (iss_valid[c] && iss_ready[c]) begin
            issued[c]++;
            if (!exp_valid) begin
                err_other++;
                $display("[%s] %s station issued an entry that was never accepted",
                         test_name, class_name(c));
            end else begin
                check_op({class_name(c), " issue_op"},
                         exp_op[c][exp_head[c] % SLOTS], iss_op[c]);
                check_reg({class_name(c), " issue_rd"},
                          exp_rd[c][exp_head[c] % SLOTS], iss_rd[c]);
                exp_head[c]++;
            end
        end
    endtask

    task automatic model_step();
        logic exp_ready;
        int   cls;
        exp_ready = predict_ready();
        check_bit("in_ready", exp_ready, in_ready);
        for (int c = 0; c < 4; c++) begin
            check_cnt({class_name(c), " stall count"}, exp_stall[c], perf_cnt[c]);
        end
        // Stall is judged on room before any pop at this edge
        if (in_valid && lane_valid[0] && !class_room(int'(lane_class[0]))) begin
            exp_stall[lane_class[0]]++;
        end
        for (int c = 0; c < 4; c++) check_issue(c);
        if (in_valid && exp_ready) begin
            for (int i = 0; i < ID_WIDTH; i++) begin
                if (lane_valid[i]) begin
                    cls = int'(lane_class[i]);
                    exp_op[cls][exp_tail[cls] % SLOTS] = lane_op[i];
                    exp_rd[cls][exp_tail[cls] % SLOTS] = lane_rd[i];
                    exp_tail[cls]++;
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (!rst) model_step();
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    // Random group with at most one BR and one MEM lane
    task automatic drive_group();
        logic               vld [ID_WIDTH];
        uop_pkg::rs_class_t cls [ID_WIDTH];
        in_valid <= ($urandom % 8) != 0;
        for (int i = 0; i < ID_WIDTH; i++) begin
            vld[i] = ($urandom % 4) != 0;
            cls[i] = uop_pkg::rs_class_t'($urandom % 4);
            for (int j = 0; j < i; j++) begin
                if (vld[j] && cls[j] == cls[i] && cls[i] >= uop_pkg::RS_BR) begin
                    cls[i] = uop_pkg::RS_INT;
                end
            end
            lane_valid[i] <= vld[i];
            lane_class[i] <= cls[i];
            lane_op[i]    <= core_cfg_pkg::op_t'($urandom);
            lane_rd[i]    <= core_cfg_pkg::phys_reg_t'($urandom);
        end
    endtask

    // One class held low for 30 cycles out of every 100
    task automatic drive_ready(input int cyc);
        logic holding;
        holding = (cyc % 100) >= 50 && (cyc % 100) < 80;
        for (int c = 0; c < 4; c++) begin
            if (holding && c == (cyc / 100) % 4) iss_ready[c] <= 1'b0;
            else iss_ready[c] <= ($urandom % 4) != 0;
        end
    endtask

    initial begin
        int cyc;
        int groups;
        seed = 32'h23f1;
        void'($urandom(seed));
        err_value = 0;
        err_other = 0;
        test_name = "reset";
        for (int c = 0; c < 4; c++) begin
            exp_head[c]  = 0;
            exp_tail[c]  = 0;
            issued[c]    = 0;
            exp_stall[c] = '0;
            iss_ready[c] <= 1'b0;
        end
        for (int i = 0; i < ID_WIDTH; i++) begin
            lane_valid[i] <= 1'b0;
            lane_class[i] <= uop_pkg::RS_INT;
            lane_op[i]    <= '0;
            lane_rd[i]    <= '0;
        end
        rst      <= 1'b1;
        in_valid <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Lane 0 offers each class in turn while in_valid stays low
        for (int c = 0; c < 4; c++) begin
            lane_valid[0] <= 1'b1;
            lane_class[0] <= uop_pkg::rs_class_t'(c);
            @(posedge clk);
            check_bit({class_name(c), " in_ready after reset"}, 1'b1, in_ready);
            check_bit({class_name(c), " issue_valid after reset"}, 1'b0, iss_valid[c]);
            check_cnt({class_name(c), " stall count after reset"}, '0, perf_cnt[c]);
        end

        test_name = "random";
        cyc    = 0;
        groups = 0;
        drive_group();
        drive_ready(cyc);
        while (groups < N_GROUPS) begin
            @(posedge clk);
            cyc++;
            if (in_valid && in_ready) groups++;
            drive_ready(cyc);
            if (groups >= N_GROUPS) in_valid <= 1'b0;
            else if (!in_valid || in_ready) drive_group();   // Blocked group is held
        end

        test_name = "drain";
        for (int c = 0; c < 4; c++) iss_ready[c] <= 1'b1;
        @(posedge clk);
        while (iss_valid[0] || iss_valid[1] || iss_valid[2] || iss_valid[3]) @(posedge clk);
        @(posedge clk);
        for (int c = 0; c < 4; c++) begin
            if (exp_tail[c] != exp_head[c] || issued[c] != exp_tail[c]) begin
                err_other++;
                $display("[drain] %s station issued %0d entries but %0d were accepted",
                         class_name(c), issued[c], exp_tail[c]);
            end
            check_cnt({class_name(c), " final stall count"}, exp_stall[c], perf_cnt[c]);
        end

        $display("Value mismatches: %0d, other errors: %0d", err_value, err_other);
        if (err_value == 0 && err_other == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: design/dispatch_top.sv
`timescale 1ns/1ns

module dispatch_top #(
    parameter int ID_WIDTH   = 2,
    parameter int INT_DEPTH  = 8,
    parameter int INTM_DEPTH = 4,
    parameter int BR_DEPTH   = 4,
    parameter int MEM_DEPTH  = 8
) (
    input  logic                    clk,
    input  logic                    rst,

    // Rename group
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    lane_valid [ID_WIDTH],
    input  uop_pkg::rs_class_t      lane_class [ID_WIDTH],
    input  core_cfg_pkg::op_t       lane_op    [ID_WIDTH],
    input  core_cfg_pkg::phys_reg_t lane_rd    [ID_WIDTH],

    // Issue ports, one per class
    output logic                    int_issue_valid,
    input  logic                    int_issue_ready,
    output core_cfg_pkg::op_t       int_issue_op,
    output core_cfg_pkg::phys_reg_t int_issue_rd,

    output logic                    intm_issue_valid,
    input  logic                    intm_issue_ready,
    output core_cfg_pkg::op_t       intm_issue_op,
    output core_cfg_pkg::phys_reg_t intm_issue_rd,

    output logic                    br_issue_valid,
    input  logic                    br_issue_ready,
    output core_cfg_pkg::op_t       br_issue_op,
    output core_cfg_pkg::phys_reg_t br_issue_rd,

    output logic                    mem_issue_valid,
    input  logic                    mem_issue_ready,
    output core_cfg_pkg::op_t       mem_issue_op,
    output core_cfg_pkg::phys_reg_t mem_issue_rd,

    // Stall counters
    output core_cfg_pkg::perf_cnt_t perf_int_stall,
    output core_cfg_pkg::perf_cnt_t perf_intm_stall,
    output core_cfg_pkg::perf_cnt_t perf_br_stall,
    output core_cfg_pkg::perf_cnt_t perf_mem_stall
);

    localparam int LANE_W = (ID_WIDTH > 1) ? $clog2(ID_WIDTH) : 1;

    logic int_has_room, intm_has_room, br_has_room, mem_has_room;
    logic int_wr_valid  [ID_WIDTH];
    logic intm_wr_valid [ID_WIDTH];
    logic br_wr_valid, mem_wr_valid;
    logic [LANE_W-1:0] br_lane, mem_lane;
    logic lane0_blocked;

    // Single-way write ports of the BR and MEM stations
    logic                    br_wr  [1];
    core_cfg_pkg::op_t       br_op  [1];
    core_cfg_pkg::phys_reg_t br_rd  [1];
    logic                    mem_wr [1];
    core_cfg_pkg::op_t       mem_op [1];
    core_cfg_pkg::phys_reg_t mem_rd [1];

    //////////////////////////////////////////////////
    // Routing and stall accounting
    //////////////////////////////////////////////////

    dispatch_router #(.ID_WIDTH(ID_WIDTH)) i_router (
        .in_valid(in_valid), .lane_valid(lane_valid), .lane_class(lane_class),
        .in_ready(in_ready),
        .int_has_room(int_has_room), .intm_has_room(intm_has_room),
        .br_has_room(br_has_room), .mem_has_room(mem_has_room),
        .int_wr_valid(int_wr_valid), .intm_wr_valid(intm_wr_valid),
        .br_wr_valid(br_wr_valid), .mem_wr_valid(mem_wr_valid),
        .br_lane(br_lane), .mem_lane(mem_lane),
        .lane0_blocked(lane0_blocked)
    );

    dispatch_perf i_perf (
        .clk(clk), .rst(rst),
        .lane0_valid(in_valid && lane_valid[0]),   // Only offered groups count
        .lane0_class(lane_class[0]), .lane0_blocked(lane0_blocked),
        .perf_int_stall(perf_int_stall), .perf_intm_stall(perf_intm_stall),
        .perf_br_stall(perf_br_stall), .perf_mem_stall(perf_mem_stall)
    );

    // Payload of the lane picked for each single-write station
    assign br_wr[0]  = br_wr_valid;
    assign br_op[0]  = lane_op[br_lane];
    assign br_rd[0]  = lane_rd[br_lane];
    assign mem_wr[0] = mem_wr_valid;
    assign mem_op[0] = lane_op[mem_lane];
    assign mem_rd[0] = lane_rd[mem_lane];

    //////////////////////////////////////////////////
    // Reservation stations
    //////////////////////////////////////////////////

    rs_queue #(.DEPTH(INT_DEPTH), .WAYS(ID_WIDTH)) i_int_rs (
        .clk(clk), .rst(rst),
        .wr_valid(int_wr_valid), .wr_op(lane_op), .wr_rd(lane_rd),
        .has_room(int_has_room),
        .issue_valid(int_issue_valid), .issue_ready(int_issue_ready),
        .issue_op(int_issue_op), .issue_rd(int_issue_rd)
    );

    rs_queue #(.DEPTH(INTM_DEPTH), .WAYS(ID_WIDTH)) i_intm_rs (
        .clk(clk), .rst(rst),
        .wr_valid(intm_wr_valid), .wr_op(lane_op), .wr_rd(lane_rd),
        .has_room(intm_has_room),
        .issue_valid(intm_issue_valid), .issue_ready(intm_issue_ready),
        .issue_op(intm_issue_op), .issue_rd(intm_issue_rd)
    );

    rs_queue #(.DEPTH(BR_DEPTH), .WAYS(1)) i_br_rs (
        .clk(clk), .rst(rst),
        .wr_valid(br_wr), .wr_op(br_op), .wr_rd(br_rd),
        .has_room(br_has_room),
        .issue_valid(br_issue_valid), .issue_ready(br_issue_ready),
        .issue_op(br_issue_op), .issue_rd(br_issue_rd)
    );

    rs_queue #(.DEPTH(MEM_DEPTH), .WAYS(1)) i_mem_rs (
        .clk(clk), .rst(rst),
        .wr_valid(mem_wr), .wr_op(mem_op), .wr_rd(mem_rd),
        .has_room(mem_has_room),
        .issue_valid(mem_issue_valid), .issue_ready(mem_issue_ready),
        .issue_op(mem_issue_op), .issue_rd(mem_issue_rd)
    );

endmodule

// File: rs/rs_queue.sv
`timescale 1ns/1ns

module rs_queue #(
    parameter int DEPTH = 8,
    parameter int WAYS  = 2
) (
    input  logic                    clk,
    input  logic                    rst,

    // Write side, from the router
    input  logic                    wr_valid [WAYS],
    input  core_cfg_pkg::op_t       wr_op    [WAYS],
    input  core_cfg_pkg::phys_reg_t wr_rd    [WAYS],
    output logic                    has_room,

    // Issue side, towards the execution unit
    output logic                    issue_valid,
    input  logic                    issue_ready,
    output core_cfg_pkg::op_t       issue_op,
    output core_cfg_pkg::phys_reg_t issue_rd
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Entry storage
    core_cfg_pkg::op_t       mem_op [DEPTH];
    core_cfg_pkg::phys_reg_t mem_rd [DEPTH];

    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0] slot [WAYS];   // Target entry for each way
    logic [CNT_W-1:0] push_cnt;
    logic             pop;

    // Pointer advance with wrap for any depth
    function automatic logic [PTR_W-1:0] ptr_add(input logic [PTR_W-1:0] ptr, input int step);
        int sum;
        sum = int'(ptr) + step;
        if (sum >= DEPTH) begin
            sum = sum - DEPTH;
        end
        return PTR_W'(sum);
    endfunction

    //////////////////////////////////////////////////
    // Write compaction
    //////////////////////////////////////////////////

    // Valid ways land back to back from the tail, lowest way first
    always_comb begin
        push_cnt = '0;
        for (int w = 0; w < WAYS; w++) begin
            slot[w]  = ptr_add(tail, int'(push_cnt));
            push_cnt = push_cnt + CNT_W'(wr_valid[w]);
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wr_valid[w]) begin
                mem_op[slot[w]] <= wr_op[w];
                mem_rd[slot[w]] <= wr_rd[w];
            end
        end
    end

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////

    assign pop = issue_valid && issue_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            tail  <= ptr_add(tail, int'(push_cnt));
            count <= count + push_cnt - CNT_W'(pop);
            if (pop) begin
                head <= ptr_add(head, 1);
            end
        end
    end

    // Room for a full write group, a pop this cycle is not credited
    assign has_room = (DEPTH - int'(count)) >= WAYS;

    //////////////////////////////////////////////////
    // Issue head
    //////////////////////////////////////////////////

    assign issue_valid = (count != '0);
    assign issue_op    = mem_op[head];   // Oldest entry
    assign issue_rd    = mem_rd[head];

endmodule

// File: dispatch/dispatch_perf.sv
`timescale 1ns/1ns

module dispatch_perf (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   lane0_valid,   // Already qualified by in_valid
    input  uop_pkg::rs_class_t     lane0_class,
    input  logic                   lane0_blocked,

    output core_cfg_pkg::perf_cnt_t perf_int_stall,
    output core_cfg_pkg::perf_cnt_t perf_intm_stall,
    output core_cfg_pkg::perf_cnt_t perf_br_stall,
    output core_cfg_pkg::perf_cnt_t perf_mem_stall
);

    logic stall;

    assign stall = lane0_valid && lane0_blocked;

    //////////////////////////////////////////////////
    // Stall counters per station class
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            perf_int_stall  <= '0;
            perf_intm_stall <= '0;
            perf_br_stall   <= '0;
            perf_mem_stall  <= '0;
        end else if (stall) begin
            // Charge the cycle to the station lane 0 waits on
            case (lane0_class)
                uop_pkg::RS_INT:  perf_int_stall  <= perf_int_stall + 1'b1;
                uop_pkg::RS_INTM: perf_intm_stall <= perf_intm_stall + 1'b1;
                uop_pkg::RS_BR:   perf_br_stall   <= perf_br_stall + 1'b1;
                default:          perf_mem_stall  <= perf_mem_stall + 1'b1;
            endcase
        end
    end

endmodule

// File: dispatch/dispatch_router.sv
`timescale 1ns/1ns

module dispatch_router #(
    parameter  int ID_WIDTH = 2,
    localparam int LANE_W   = (ID_WIDTH > 1) ? $clog2(ID_WIDTH) : 1
) (
    // Group from rename
    input  logic                in_valid,
    input  logic                lane_valid [ID_WIDTH],
    input  uop_pkg::rs_class_t  lane_class [ID_WIDTH],
    output logic                in_ready,

    // Room reported by the stations
    input  logic                int_has_room,
    input  logic                intm_has_room,
    input  logic                br_has_room,
    input  logic                mem_has_room,

    // Write strobes towards the stations
    output logic                int_wr_valid  [ID_WIDTH],
    output logic                intm_wr_valid [ID_WIDTH],
    output logic                br_wr_valid,
    output logic                mem_wr_valid,
    output logic [LANE_W-1:0]   br_lane,
    output logic [LANE_W-1:0]   mem_lane,

    output logic                lane0_blocked
);

    logic lane_ready [ID_WIDTH];
    logic accept;
    logic br_found;
    logic mem_found;

    //////////////////////////////////////////////////
    // Group ready
    //////////////////////////////////////////////////

    // An invalid lane never holds the group back
    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            case (lane_class[i])
                uop_pkg::RS_INT:  lane_ready[i] = !lane_valid[i] || int_has_room;
                uop_pkg::RS_INTM: lane_ready[i] = !lane_valid[i] || intm_has_room;
                uop_pkg::RS_BR:   lane_ready[i] = !lane_valid[i] || br_has_room;
                default:          lane_ready[i] = !lane_valid[i] || mem_has_room;
            endcase
        end
    end

    always_comb begin
        in_ready = 1'b1;
        for (int i = 0; i < ID_WIDTH; i++) begin
            in_ready = in_ready && lane_ready[i];
        end
    end

    assign accept        = in_valid && in_ready;
    assign lane0_blocked = lane_valid[0] && !lane_ready[0];

    //////////////////////////////////////////////////
    // Wide stations, one strobe per lane
    //////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            int_wr_valid[i]  = accept && lane_valid[i] && (lane_class[i] == uop_pkg::RS_INT);
            intm_wr_valid[i] = accept && lane_valid[i] && (lane_class[i] == uop_pkg::RS_INTM);
        end
    end

    //////////////////////////////////////////////////
    // Single-write stations, lowest lane wins
    //////////////////////////////////////////////////

    always_comb begin
        br_found  = 1'b0;
        mem_found = 1'b0;
        br_lane   = '0;
        mem_lane  = '0;
        // Scan from the top so the lowest matching lane is kept last
        for (int i = ID_WIDTH - 1; i >= 0; i--) begin
            if (lane_valid[i] && (lane_class[i] == uop_pkg::RS_BR)) begin
                br_found = 1'b1;
                br_lane  = LANE_W'(i);
            end
            if (lane_valid[i] && (lane_class[i] == uop_pkg::RS_MEM)) begin
                mem_found = 1'b1;
                mem_lane  = LANE_W'(i);
            end
        end
    end

    assign br_wr_valid  = accept && br_found;
    assign mem_wr_valid = accept && mem_found;

endmodule

// File: common/uop_pkg.sv
package uop_pkg;

    //////////////////////////////////////////////////
    // Reservation station classes
    //////////////////////////////////////////////////

    // Which station a micro-op is dispatched to
    typedef logic [1:0] rs_class_t;

    localparam rs_class_t RS_INT  = 2'd0;  // Simple integer ALU ops
    localparam rs_class_t RS_INTM = 2'd1;  // Integer multiply and divide
    localparam rs_class_t RS_BR   = 2'd2;  // Branches, one per group
    localparam rs_class_t RS_MEM  = 2'd3;  // Loads and stores, one per group

endpackage

// File: common/core_cfg_pkg.sv
package core_cfg_pkg;

    //////////////////////////////////////////////////
    // Datapath widths
    //////////////////////////////////////////////////

    // Physical destination register number
    typedef logic [5:0]  phys_reg_t;

    // Micro-op opcode, already decoded by rename
    typedef logic [4:0]  op_t;

    //////////////////////////////////////////////////
    // Performance monitoring
    //////////////////////////////////////////////////

    typedef logic [31:0] perf_cnt_t;    // Wraps on overflow

endpackage
